// File: bsr_format_pkg.sv
`default_nettype none

// ==============================
// BSR storage format
// ==============================
// row_ptr[r] and row_ptr[r+1] bound the blocks of block row r
// col_idx[j] gives the block column of global block j
package bsr_format_pkg;

    // Metadata region selector, sent with every read
    typedef enum logic [1:0] {
        META_ROW_PTR = 2'd0,  // Row pointer table, addressed by row number
        META_COL_IDX = 2'd1   // Column index table, addressed by block index
    } meta_kind_e;

    parameter int META_ADDR_W = 8;   // Metadata word address
    parameter int BLK_IDX_W   = 16;  // Global block index and row pointer values
    parameter int BLK_POS_W   = 16;  // Block row / block column numbers

    // One metadata read request, 10 bits
    typedef struct packed {
        meta_kind_e             kind;  // Which table
        logic [META_ADDR_W-1:0] addr;  // Word within the table
    } meta_req_t;

endpackage : bsr_format_pkg

`default_nettype wire

// File: bsr_sched_pkg.sv
`default_nettype none

// ==============================
// Scheduler types
// ==============================
package bsr_sched_pkg;

    import bsr_format_pkg::*;

    // Block walk FSM
    typedef enum logic [3:0] {
        IDLE        = 4'd0,   // Wait for start
        ROW_PTR_LO  = 4'd1,   // Fetch row_ptr[r]
        ROW_PTR_HI  = 4'd2,   // Fetch row_ptr[r+1]
        CHECK_EMPTY = 4'd3,   // Compare pointers, skip empty row
        COL_IDX     = 4'd4,   // Fetch col_idx[j]
        LOAD        = 4'd5,   // Byte-serial block load
        OFFER       = 4'd6,   // Hold block on systolic port until ready
        WAIT_DONE   = 4'd7,   // Array computing
        NEXT_BLOCK  = 4'd8,   // Step block index within row
        NEXT_ROW    = 4'd9,   // Step block row
        FINISH      = 4'd10   // Run complete
    } sched_state_e;

    // Position of the offered block in the block grid, 32 bits
    typedef struct packed {
        logic [BLK_POS_W-1:0] row;  // Block row
        logic [BLK_POS_W-1:0] col;  // Block column
    } block_pos_t;

endpackage : bsr_sched_pkg

`default_nettype wire

// File: bsr_meta_reader.sv
`default_nettype none

// Single outstanding metadata read
// Request is launched one cycle after meta_go, the word is kept until the next ack
module bsr_meta_reader
    import bsr_format_pkg::*;
(
    input  wire logic        clk_gated,
    input  wire logic        rst_n,
    input  wire logic        meta_go,        // Pulse from FSM
    input  wire meta_req_t   req,            // Request captured on meta_go
    input  wire logic [31:0] meta_rd_data,
    input  wire logic        meta_rd_valid,  // One-cycle strobe, variable delay
    output logic             meta_rd_en,     // One-cycle read pulse
    output meta_req_t        meta_req,       // Held on the port while pending
    output logic [31:0]      meta_word,      // Last returned word
    output logic             meta_ack        // Same cycle as meta_rd_valid
);

    logic pending;  // Read issued, data not back yet

    // Data only counts for a read we actually issued
    assign meta_ack = pending & meta_rd_valid;

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk_gated or negedge rst_n) begin
        if (!rst_n) begin
            meta_rd_en <= 1'b0;
            pending    <= 1'b0;
        end else begin
            meta_rd_en <= meta_go;  // Pulse follows go by one cycle
            if (meta_go) begin
                pending <= 1'b1;
            end else if (meta_ack) begin
                pending <= 1'b0;   // Return closes the transaction
            end
        end
    end

    // ==============================
    // Request and returned word
    // ==============================
    always_ff @(posedge clk_gated) begin
        if (meta_go) begin
            meta_req <= req;  // Stays on the port until the next go
        end
        if (meta_ack) begin
            meta_word <= meta_rd_data;  // Visible to the FSM from the cycle after ack
        end
    end

endmodule : bsr_meta_reader

`default_nettype wire

// File: bsr_block_loader.sv
`default_nettype none

// Byte-serial block fetch into a packed buffer
// load_go at cycle 0, reads issued in cycles 1..N, load_done in cycle N+1
module bsr_block_loader
    import bsr_format_pkg::*;
#(
    parameter int BLOCK_DIM = 8
) (
    input  wire logic                 clk_gated,
    input  wire logic                 rst_n,
    input  wire logic                 load_go,        // Pulse from FSM
    input  wire logic [BLK_IDX_W-1:0] load_idx,       // Global block index
    input  wire logic [7:0]           block_rd_data,  // Valid one cycle after enable
    output logic                      block_rd_en,
    output logic [31:0]               block_rd_addr,
    output logic [8*BLOCK_DIM*BLOCK_DIM-1:0] block_data,  // Byte k at [8k +: 8]
    output logic                      load_done
);

    localparam int NBYTES = BLOCK_DIM * BLOCK_DIM;
    localparam int CNT_W  = (NBYTES > 1) ? $clog2(NBYTES) : 1;

    logic             active;    // Read phase running
    logic [CNT_W-1:0] cnt;       // Byte being requested
    logic [31:0]      base;      // Block start address in memory
    logic             vld_d;     // Read data present this cycle
    logic [CNT_W-1:0] cnt_d;     // Slot of the byte in block_rd_data

    assign block_rd_en   = active;
    assign block_rd_addr = base + 32'(cnt);
    assign load_done     = vld_d & (cnt_d == CNT_W'(NBYTES - 1));  // Last byte lands now

    // ==============================
    // Address sequencing
    // ==============================
    always_ff @(posedge clk_gated or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            vld_d  <= 1'b0;
        end else begin
            vld_d <= active;  // Memory returns one cycle later
            if (load_go) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(NBYTES - 1)) begin
                    active <= 1'b0;  // Final address issued
                end
            end
        end
    end

    // Payload side
    always_ff @(posedge clk_gated) begin
        if (load_go) begin
            base <= 32'(load_idx) * 32'(NBYTES);  // idx * bytes per block
        end
        cnt_d <= cnt;
        if (vld_d) begin
            block_data[8*cnt_d +: 8] <= block_rd_data;  // Held until the next load
        end
    end

endmodule : bsr_block_loader

`default_nettype wire

// File: bsr_sched_fsm.sv
`default_nettype none

// Block row walk
// Metadata states issue meta_go on entry and leave on meta_ack
// The word of an ack is read from meta_word one cycle later
module bsr_sched_fsm
    import bsr_format_pkg::*;
    import bsr_sched_pkg::*;
(
    input  wire logic                 clk_gated,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire logic [15:0]          cfg_num_block_rows,
    input  wire logic [31:0]          meta_word,
    input  wire logic                 meta_ack,
    input  wire logic                 load_done,
    input  wire logic                 systolic_ready,
    input  wire logic                 systolic_done,
    output logic                      meta_go,
    output meta_req_t                 req,
    output logic                      load_go,
    output logic [BLK_IDX_W-1:0]      load_idx,
    output logic                      systolic_valid,
    output block_pos_t                systolic_pos,
    output logic                      busy,
    output logic                      done,
    output logic [31:0]               blocks_processed
);

    sched_state_e         state;
    logic [15:0]          num_rows;   // Latched at start
    logic [BLK_POS_W-1:0] row;        // Current block row
    logic [BLK_IDX_W-1:0] row_start;  // row_ptr[row]
    logic [BLK_IDX_W-1:0] row_end;    // row_ptr[row+1]
    logic [BLK_IDX_W-1:0] blk_idx;    // Current global block

    // ==============================
    // Walk FSM
    // ==============================
    always_ff @(posedge clk_gated or negedge rst_n) begin
        if (!rst_n) begin
            state            <= IDLE;
            num_rows         <= '0;
            row              <= '0;
            row_start        <= '0;
            row_end          <= '0;
            blk_idx          <= '0;
            meta_go          <= 1'b0;
            req              <= '0;
            load_go          <= 1'b0;
            load_idx         <= '0;
            systolic_valid   <= 1'b0;
            systolic_pos     <= '0;
            busy             <= 1'b0;
            done             <= 1'b0;
            blocks_processed <= '0;
        end else begin
            meta_go <= 1'b0;  // Pulses
            load_go <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        num_rows         <= cfg_num_block_rows;
                        row              <= '0;
                        blocks_processed <= '0;
                        done             <= 1'b0;
                        if (cfg_num_block_rows == 16'd0) begin
                            state <= FINISH;  // Nothing to walk
                            done  <= 1'b1;
                        end else begin
                            busy     <= 1'b1;
                            meta_go  <= 1'b1;
                            req.kind <= META_ROW_PTR;
                            req.addr <= '0;
                            state    <= ROW_PTR_LO;
                        end
                    end
                end
                ROW_PTR_LO: begin
                    if (meta_ack) begin
                        meta_go  <= 1'b1;  // Second pointer, row + 1
                        req.kind <= META_ROW_PTR;
                        req.addr <= META_ADDR_W'(row + 1'b1);
                        state    <= ROW_PTR_HI;
                    end
                end
                ROW_PTR_HI: begin
                    if (meta_ack) begin
                        row_start <= meta_word[BLK_IDX_W-1:0];  // Still the first pointer
                        state     <= CHECK_EMPTY;
                    end
                end
                CHECK_EMPTY: begin
                    row_end <= meta_word[BLK_IDX_W-1:0];  // Second pointer now
                    blk_idx <= row_start;
                    if (meta_word[BLK_IDX_W-1:0] == row_start) begin
                        state <= NEXT_ROW;  // Empty row, no blocks
                    end else begin
                        meta_go  <= 1'b1;
                        req.kind <= META_COL_IDX;
                        req.addr <= row_start[META_ADDR_W-1:0];
                        state    <= COL_IDX;
                    end
                end
                COL_IDX: begin
                    if (meta_ack) begin
                        load_go  <= 1'b1;
                        load_idx <= blk_idx;
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (load_done) begin
                        systolic_valid   <= 1'b1;
                        systolic_pos.row <= row;
                        systolic_pos.col <= meta_word[BLK_POS_W-1:0];  // Column from ack
                        state            <= OFFER;
                    end
                end
                OFFER: begin
                    if (systolic_ready) begin  // Hand-over, else everything held
                        systolic_valid <= 1'b0;
                        state          <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (systolic_done) begin
                        blocks_processed <= blocks_processed + 32'd1;
                        state            <= NEXT_BLOCK;
                    end
                end
                NEXT_BLOCK: begin
                    if (blk_idx + 1'b1 == row_end) begin
                        state <= NEXT_ROW;  // Row exhausted
                    end else begin
                        blk_idx  <= blk_idx + 1'b1;
                        meta_go  <= 1'b1;
                        req.kind <= META_COL_IDX;
                        req.addr <= META_ADDR_W'(blk_idx + 1'b1);
                        state    <= COL_IDX;
                    end
                end
                NEXT_ROW: begin
                    if (row + 1'b1 == num_rows) begin
                        state <= FINISH;
                        busy  <= 1'b0;
                        done  <= 1'b1;  // High from FINISH on
                    end else begin
                        row      <= row + 1'b1;
                        meta_go  <= 1'b1;  // Both pointers re-read
                        req.kind <= META_ROW_PTR;
                        req.addr <= META_ADDR_W'(row + 1'b1);
                        state    <= ROW_PTR_LO;
                    end
                end
                FINISH: begin
                    state <= IDLE;  // done stays until next start
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule : bsr_sched_fsm

`default_nettype wire

// File: bsr_scheduler.sv
`default_nettype none

// BSR scheduler top
// FSM drives the metadata reader and the block loader, block buffer goes straight out
module bsr_scheduler
    import bsr_format_pkg::*;
    import bsr_sched_pkg::*;
#(
    parameter int BLOCK_DIM = 8  // Block is BLOCK_DIM x BLOCK_DIM bytes
) (
    input  wire logic        clk_gated,
    input  wire logic        rst_n,
    input  wire logic        start,
    input  wire logic [15:0] cfg_num_block_rows,
    // Metadata port
    output logic             meta_rd_en,
    output meta_req_t        meta_req,
    input  wire logic [31:0] meta_rd_data,
    input  wire logic        meta_rd_valid,
    // Block data port
    output logic             block_rd_en,
    output logic [31:0]      block_rd_addr,
    input  wire logic [7:0]  block_rd_data,
    // Systolic port
    output logic             systolic_valid,
    output logic [8*BLOCK_DIM*BLOCK_DIM-1:0] systolic_block,
    output block_pos_t       systolic_pos,
    input  wire logic        systolic_ready,
    input  wire logic        systolic_done,
    // Status
    output logic             busy,
    output logic             done,
    output logic [31:0]      blocks_processed
);

    // ==============================
    // Internal wiring
    // ==============================
    logic                 meta_go;    // FSM -> reader
    meta_req_t            fsm_req;
    logic [31:0]          meta_word;  // Reader -> FSM
    logic                 meta_ack;
    logic                 load_go;    // FSM -> loader
    logic [BLK_IDX_W-1:0] load_idx;
    logic                 load_done;  // Loader -> FSM

    bsr_meta_reader i_bsr_meta_reader (
        .clk_gated     (clk_gated),
        .rst_n         (rst_n),
        .meta_go       (meta_go),
        .req           (fsm_req),
        .meta_rd_data  (meta_rd_data),
        .meta_rd_valid (meta_rd_valid),
        .meta_rd_en    (meta_rd_en),
        .meta_req      (meta_req),
        .meta_word     (meta_word),
        .meta_ack      (meta_ack)
    );

    bsr_block_loader #(
        .BLOCK_DIM (BLOCK_DIM)
    ) i_bsr_block_loader (
        .clk_gated     (clk_gated),
        .rst_n         (rst_n),
        .load_go       (load_go),
        .load_idx      (load_idx),
        .block_rd_data (block_rd_data),
        .block_rd_en   (block_rd_en),
        .block_rd_addr (block_rd_addr),
        .block_data    (systolic_block),  // Buffer is stable through OFFER
        .load_done     (load_done)
    );

    bsr_sched_fsm i_bsr_sched_fsm (
        .clk_gated          (clk_gated),
        .rst_n              (rst_n),
        .start              (start),
        .cfg_num_block_rows (cfg_num_block_rows),
        .meta_word          (meta_word),
        .meta_ack           (meta_ack),
        .load_done          (load_done),
        .systolic_ready     (systolic_ready),
        .systolic_done      (systolic_done),
        .meta_go            (meta_go),
        .req                (fsm_req),
        .load_go            (load_go),
        .load_idx           (load_idx),
        .systolic_valid     (systolic_valid),
        .systolic_pos       (systolic_pos),
        .busy               (busy),
        .done               (done),
        .blocks_processed   (blocks_processed)
    );

endmodule : bsr_scheduler

`default_nettype wire

// File: bsr_checker.sv
`default_nettype none

// Scoreboard for the systolic port and the run status
// Samples on the falling edge, where every DUT output has settled
module bsr_checker
    import bsr_sched_pkg::*;
#(
    parameter int BLOCK_DIM = 8
) (
    input  wire logic                             clk_gated,
    input  wire logic                             rst_n,
    input  wire logic                             start,
    input  wire logic                             meta_rd_en,
    input  wire logic                             block_rd_en,
    input  wire logic                             systolic_valid,
    input  wire logic                             systolic_ready,
    input  wire block_pos_t                       systolic_pos,
    input  wire logic [8*BLOCK_DIM*BLOCK_DIM-1:0] systolic_block,
    input  wire logic                             busy,
    input  wire logic                             done,
    input  wire logic [31:0]                      blocks_processed
);

    localparam int DW = 8 * BLOCK_DIM * BLOCK_DIM;  // Block payload bits

    block_pos_t    exp_pos [$];   // Expected offers, in order
    logic [DW-1:0] exp_data [$];
    int            exp_count = 0; // Final blocks_processed
    int            err_cnt   = 0;
    logic          hold_q    = 1'b0;  // Offer stalled in the previous cycle
    block_pos_t    pos_q;
    logic [DW-1:0] data_q;
    logic          start_q   = 1'b0;
    logic          done_q    = 1'b0;

    // ==============================
    // Expectation loading
    // ==============================
    task automatic clear_expected();
        exp_pos.delete();
        exp_data.delete();
    endtask

    task automatic push_block(input block_pos_t pos, input logic [DW-1:0] data);
        exp_pos.push_back(pos);
        exp_data.push_back(data);
    endtask

    task automatic set_final_count(input int n);
        exp_count = n;
    endtask

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic report_event(input string what);
        err_cnt++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // ==============================
    // Per-cycle checks
    // ==============================
    always @(negedge clk_gated) begin
        if (!rst_n) begin
            check_value("busy", busy, 1'b0);  // Reset values
            check_value("done", done, 1'b0);
            check_value("meta_rd_en", meta_rd_en, 1'b0);
            check_value("block_rd_en", block_rd_en, 1'b0);
            check_value("systolic_valid", systolic_valid, 1'b0);
            check_value("blocks_processed", blocks_processed, 32'd0);
            hold_q = 1'b0;
        end else begin
            if (hold_q) begin  // Stalled offer must not move
                check_value("systolic_valid", systolic_valid, 1'b1);
                check_value("systolic_pos", systolic_pos, pos_q);
                check_value("systolic_block", systolic_block, data_q);
            end
            if (systolic_valid && systolic_ready) begin  // Hand-over
                if (exp_pos.size() == 0) begin
                    report_event("block offered when none was expected");
                end else begin
                    check_value("systolic_pos", systolic_pos, exp_pos.pop_front());
                    check_value("systolic_block", systolic_block, exp_data.pop_front());
                end
                check_value("busy", busy, 1'b1);
                check_value("done", done, 1'b0);
            end
            if (start_q) begin
                check_value("done", done, 1'b0);  // Cleared by the start just taken
            end
            if (done && !done_q) begin  // End of run
                check_value("busy", busy, 1'b0);
                check_value("blocks_processed", blocks_processed, exp_count);
                if (exp_pos.size() != 0) begin
                    report_event($sformatf("%0d expected blocks never offered",
                                           exp_pos.size()));
                end
            end
            hold_q = systolic_valid && !systolic_ready;
        end
        pos_q   = systolic_pos;
        data_q  = systolic_block;
        start_q = start;
        done_q  = done;
    end

endmodule : bsr_checker

`default_nettype wire

// File: tb_bsr_scheduler.sv
`default_nettype none

// BSR scheduler testbench
// Table rows are applied in turn, metadata, block memory and array are modelled here
module tb_bsr_scheduler
    import bsr_format_pkg::*;
    import bsr_sched_pkg::*;
();

    localparam int BLOCK_DIM = 8;
    localparam int NB        = BLOCK_DIM * BLOCK_DIM;  // Bytes per block
    localparam int NTESTS    = 5;
    localparam int DONE_LAT  = 3;   // Array compute cycles after hand-over
    localparam int MEM_BYTES = 16 * NB;

    // Row layout: rows, row_ptr[0..6], col_idx[0..11], stall, metadata latency
    typedef struct packed {
        logic [7:0]       rows;
        logic [0:6][7:0]  ptr;
        logic [0:11][7:0] col;
        logic [7:0]       stall;  // Extra cycles with ready low
        logic [7:0]       mdly;   // Base metadata latency, at least 1
    } test_t;

    logic            clk_gated;
    logic            rst_n;
    logic            start;
    logic [15:0]     cfg_num_block_rows;
    logic            meta_rd_en;
    meta_req_t       meta_req;
    logic [31:0]     meta_rd_data;
    logic            meta_rd_valid;
    logic            block_rd_en;
    logic [31:0]     block_rd_addr;
    logic [7:0]      block_rd_data;
    logic            systolic_valid;
    logic [8*NB-1:0] systolic_block;
    block_pos_t      systolic_pos;
    logic            systolic_ready;
    logic            systolic_done;
    logic            busy;
    logic            done;
    logic [31:0]     blocks_processed;

    test_t      tests [NTESTS];
    string      names [NTESTS];
    test_t      cur;                    // Row seen by the models
    logic [7:0] block_mem [MEM_BYTES];
    logic       table_ready = 1'b0;
    int         meta_reads  = 0;        // Varies the metadata latency
    meta_req_t  req_q;
    logic [31:0] blk_addr;

    bsr_scheduler #(.BLOCK_DIM(BLOCK_DIM)) i_bsr_scheduler (
        .clk_gated(clk_gated), .rst_n(rst_n), .start(start),
        .cfg_num_block_rows(cfg_num_block_rows),
        .meta_rd_en(meta_rd_en), .meta_req(meta_req),
        .meta_rd_data(meta_rd_data), .meta_rd_valid(meta_rd_valid),
        .block_rd_en(block_rd_en), .block_rd_addr(block_rd_addr),
        .block_rd_data(block_rd_data),
        .systolic_valid(systolic_valid), .systolic_block(systolic_block),
        .systolic_pos(systolic_pos), .systolic_ready(systolic_ready),
        .systolic_done(systolic_done),
        .busy(busy), .done(done), .blocks_processed(blocks_processed)
    );

    bsr_checker #(.BLOCK_DIM(BLOCK_DIM)) i_bsr_checker (
        .clk_gated(clk_gated), .rst_n(rst_n), .start(start),
        .meta_rd_en(meta_rd_en), .block_rd_en(block_rd_en),
        .systolic_valid(systolic_valid), .systolic_ready(systolic_ready),
        .systolic_pos(systolic_pos), .systolic_block(systolic_block),
        .busy(busy), .done(done), .blocks_processed(blocks_processed)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk_gated = 1'b0;
        forever #50 clk_gated = ~clk_gated;
    end

    // ==============================
    // Memory and array models
    // ==============================
    always begin  // Metadata, one read in flight
        @(posedge clk_gated);
        if (meta_rd_en) begin
            req_q = meta_req;
            repeat (int'(cur.mdly) - 1 + meta_reads % 3) @(posedge clk_gated);
            #10;
            meta_rd_valid = 1'b1;
            meta_rd_data  = {6'b101101, req_q, 8'd0,  // Upper half is junk
                             (req_q.kind == META_ROW_PTR) ? cur.ptr[req_q.addr]
                                                          : cur.col[req_q.addr]};
            meta_reads++;
            @(posedge clk_gated);
            #10 meta_rd_valid = 1'b0;
        end
    end

    always @(posedge clk_gated) begin  // Block bytes, one cycle latency
        if (block_rd_en) begin
            blk_addr = block_rd_addr;
            #10 block_rd_data = block_mem[blk_addr];
        end
    end

    always begin  // Systolic array
        @(posedge clk_gated);
        if (systolic_valid) begin
            repeat (cur.stall) @(posedge clk_gated);
            #10 systolic_ready = 1'b1;
            @(posedge clk_gated);                   // Hand-over edge
            #10 systolic_ready = 1'b0;
            repeat (DONE_LAT - 1) @(posedge clk_gated);
            #10 systolic_done = 1'b1;
            @(posedge clk_gated);
            #10 systolic_done = 1'b0;
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        logic [31:0]     seed;
        block_pos_t      pos;
        logic [8*NB-1:0] data;
        int              prev_errs;
        int              passed;

        rst_n              = 1'b0;
        start              = 1'b0;
        cfg_num_block_rows = '0;
        meta_rd_data       = '0;
        meta_rd_valid      = 1'b0;
        block_rd_data      = '0;
        systolic_ready     = 1'b0;
        systolic_done      = 1'b0;
        passed             = 0;
        seed               = 32'h7c6b_2e1e;
        for (int a = 0; a < MEM_BYTES; a++) begin
            seed         = lcg_next(seed);
            block_mem[a] = seed[31:24];
        end
        tests[0] = {8'd3, 56'h00_02_03_05_00_00_00, 96'h03_01_00_02_04_00_00_00_00_00_00_00,
                    8'd0, 8'd1};
        names[0] = "dense rows";
        tests[1] = {8'd4, 56'h00_00_02_02_03_00_00, 96'h05_02_07_00_00_00_00_00_00_00_00_00,
                    8'd0, 8'd3};
        names[1] = "empty rows";
        tests[2] = {8'd3, 56'h04_04_04_04_00_00_00, 96'h0, 8'd0, 8'd2};
        names[2] = "all rows empty";
        tests[3] = {8'd2, 56'h00_02_03_00_00_00_00, 96'h01_00_02_00_00_00_00_00_00_00_00_00,
                    8'd5, 8'd1};
        names[3] = "back-pressure";
        tests[4] = {8'd2, 56'h09_0b_0c_00_00_00_00, 96'h00_00_00_00_00_00_00_00_00_04_06_01,
                    8'd2, 8'd4};
        names[4] = "slow metadata";
        cur         = tests[0];
        table_ready = 1'b1;
        repeat (2) @(posedge clk_gated);
        #10 rst_n = 1'b1;

        for (int t = 0; t < NTESTS; t++) begin
            cur       = tests[t];
            prev_errs = i_bsr_checker.err_cnt;
            i_bsr_checker.clear_expected();
            for (int r = 0; r < int'(cur.rows); r++) begin  // Row-major, index order
                for (int j = int'(cur.ptr[r]); j < int'(cur.ptr[r + 1]); j++) begin
                    pos.row = 16'(r);
                    pos.col = 16'(cur.col[j]);
                    for (int k = 0; k < NB; k++) begin
                        data[8*k +: 8] = block_mem[j * NB + k];
                    end
                    i_bsr_checker.push_block(pos, data);
                end
            end
            i_bsr_checker.set_final_count(int'(cur.ptr[cur.rows]) - int'(cur.ptr[0]));
            @(posedge clk_gated);
            #10;
            cfg_num_block_rows = 16'(cur.rows);
            start              = 1'b1;
            @(posedge clk_gated);
            #10 start = 1'b0;
            while (!done) @(posedge clk_gated);
            if (i_bsr_checker.err_cnt == prev_errs) begin
                passed++;
                $display("Test %0d (%s): PASS, %0d blocks", t, names[t], blocks_processed);
            end else begin
                $display("Test %0d (%s): FAIL, %0d errors", t, names[t],
                         i_bsr_checker.err_cnt - prev_errs);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 NTESTS, passed, NTESTS - passed, i_bsr_checker.err_cnt);
        if (i_bsr_checker.err_cnt == 0 && passed == NTESTS) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        int limit;

        limit = 200;
        wait (table_ready);
        for (int t = 0; t < NTESTS; t++) begin  // Blocks * (bytes + stall + 40)
            limit += (int'(tests[t].ptr[tests[t].rows]) - int'(tests[t].ptr[0]))
                     * (NB + int'(tests[t].stall) + 40);
        end
        repeat (limit) @(posedge clk_gated);
        $display("Timeout: run not finished after %0d cycles", limit);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_bsr_scheduler

`default_nettype wire

// File: src.f
bsr_format_pkg.sv
bsr_sched_pkg.sv
bsr_meta_reader.sv
bsr_block_loader.sv
bsr_sched_fsm.sv
bsr_scheduler.sv
bsr_checker.sv
tb_bsr_scheduler.sv
